//--- common/ucode_pkg.sv
package ucode_pkg;

   // entry point into the control store, supplied by decode stage 1
   typedef logic [7:0] ucode_addr_t;

   // one control store entry
   // a value field sits next to its select; select high takes the value
   // from the word and select low takes the default decoded from modrm.
   // size selects without a value force 32 bits, mux_seg1 forces ES,
   // mux_seg2 takes the modrm reg field instead of SS
   typedef struct packed {
      // operand size, override by 66 allowed while mux_op_size is low
      logic [1:0] op_size;
      logic       mux_op_size;
      logic       mux_sr1_size;
      logic [1:0] sr2_size;
      logic       mux_sr2_size;
      logic       mux_dr1_size;
      logic       mux_dr2_size;
      // alu function, default is the modrm reg field
      logic [2:0] alu_op;
      logic       mux_alu_op;
      // source registers, defaults are base/rm and reg
      logic [2:0] sr1;
      logic       mux_sr1;
      logic [2:0] sr2;
      logic       mux_sr2;
      // memory strobes, default follows a memory mod
      logic       mem_rd;
      logic       mux_mem_rd;
      logic       dcache_write;
      logic       mux_mem_wr;
      // write-back loads
      logic       ld_gpr1;
      logic       ld_mm;
      // operands AG has to fetch
      logic       sr1_needed;
      logic       seg1_needed;
      logic       mux_seg1_needed;
      logic       mm1_needed;
      logic       is_far_call;
      logic       mux_seg1;
      logic       mux_seg2;
   } ucode_word_t;

endpackage

//--- common/x86_pkg.sv
package x86_pkg;

   // architectural field widths
   typedef logic [2:0] reg_id_t;
   typedef logic [2:0] seg_id_t;
   typedef logic [1:0] size_code_t;
   typedef logic [2:0] alu_op_t;

   // instruction register depth in bytes
   localparam int ir_len_bytes = 16;
   typedef logic [$clog2(ir_len_bytes)-1:0] byte_sel_t;

   // segment register encoding
   localparam seg_id_t seg_es = 3'd0;
   localparam seg_id_t seg_cs = 3'd1;
   localparam seg_id_t seg_ss = 3'd2;
   localparam seg_id_t seg_ds = 3'd3;
   localparam seg_id_t seg_fs = 3'd4;
   localparam seg_id_t seg_gs = 3'd5;

   localparam size_code_t size_8  = 2'd0;
   localparam size_code_t size_16 = 2'd1;
   localparam size_code_t size_32 = 2'd2;
   localparam size_code_t size_64 = 2'd3;

   // alu codes match the reg field of the 80..83 group
   localparam alu_op_t alu_add = 3'd0;
   localparam alu_op_t alu_sub = 3'd5;
   localparam alu_op_t alu_cmp = 3'd7;

   localparam reg_id_t reg_esp = 3'd4;
   localparam reg_id_t reg_ebp = 3'd5;

   typedef struct packed {
      logic [1:0] mod;
      reg_id_t    reg_op;
      reg_id_t    rm;
   } modrm_t;

   typedef struct packed {
      logic [1:0] scale;
      reg_id_t    index;
      reg_id_t    base;
   } sib_t;

   // fields found by decode stage 1, ir byte 0 sits in ir[7:0]
   typedef struct packed {
      logic [ir_len_bytes*8-1:0] ir;
      logic [31:0]               eip;
      logic [15:0]               cs;
      logic [3:0]                instr_length;
      // one-byte opcodes carry 00 in the upper byte
      logic [15:0]               opcode;
      logic                      opcode_size;
      logic                      segment_override;
      logic                      operand_override;
      logic                      modrm_present;
      logic                      sib_present;
      logic                      disp_present;
      logic                      imm_present;
      logic                      offset_present;
      byte_sel_t                 disp_sel;
      byte_sel_t                 imm_sel;
      byte_sel_t                 off_sel;
      size_code_t                disp_size;
      size_code_t                imm_size;
      size_code_t                offset_size;
      seg_id_t                   seg_id;
      modrm_t                    modrm;
      sib_t                      sib;
      ucode_pkg::ucode_addr_t    ucode_addr;
      logic                      valid;
   } d2_in_t;

   // bundle handed to address generation
   typedef struct packed {
      logic [31:0] eip;
      logic [15:0] cs;
      logic [31:0] disp;
      logic [31:0] imm;
      logic [47:0] offset;
      size_code_t  sr1_size;
      size_code_t  sr2_size;
      size_code_t  dr1_size;
      size_code_t  dr2_size;
      size_code_t  mem_size;
      logic        sr1_needed;
      logic        seg1_needed;
      logic        mm1_needed;
      logic        mem_rd;
      logic        mem_wr;
      alu_op_t     alu_op;
      logic        ld_gpr1;
      logic        ld_mm;
      reg_id_t     sr1;
      reg_id_t     sr2;
      reg_id_t     sr3;
      reg_id_t     sr4;
      seg_id_t     seg1;
      seg_id_t     seg2;
      logic        sib_en;
      logic        disp_en;
      logic        base_en;
      logic        mux_seg;
      logic        cmpxchg;
      logic [1:0]  sib_scale;
      logic        valid;
   } d2_out_t;

endpackage

//--- compile.f
common/ucode_pkg.sv
common/x86_pkg.sv
decode2/field_extract.sv
decode2/ucontrol_store.sv
decode2/seg_select.sv
decode2/decode_stage2.sv
logic/d2_ag_latch.sv
logic/decode2_top.sv
verif/tb_clock.sv
verif/tb_decode2.sv

//--- decode2/decode_stage2.sv
`timescale 1ns/1ps

module decode_stage2 #(
   parameter int ir_bytes = 16
) (
   input  x86_pkg::d2_in_t  d2_in,
   output x86_pkg::d2_out_t d2_out
);
   import x86_pkg::*;
   import ucode_pkg::*;

   ucode_word_t cw;
   logic        mod_is_reg;
   logic        mod_is_mem;
   logic        op_0f7f;
   logic        offset_ovr;
   size_code_t  ovr_size;
   size_code_t  op_size;
   reg_id_t     base_reg;
   seg_id_t     seg_sel;
   logic [31:0] disp;
   logic [31:0] imm;
   logic [47:0] offset;

   ucontrol_store u_ucontrol_store (
      .addr        (d2_in.ucode_addr),
      .opcode_size (d2_in.opcode_size),
      .word        (cw)
   );

   field_extract #(
      .ir_bytes (ir_bytes)
   ) u_field_extract (
      .ir          (d2_in.ir),
      .disp_sel    (d2_in.disp_sel),
      .disp_size   (d2_in.disp_size),
      .imm_sel     (d2_in.imm_sel),
      .imm_size    (d2_in.imm_size),
      .off_sel     (d2_in.off_sel),
      .offset_size (d2_in.offset_size),
      .offset_ovr  (offset_ovr),
      .disp        (disp),
      .imm         (imm),
      .offset      (offset)
   );

   seg_select u_seg_select (
      .opcode           (d2_in.opcode),
      .modrm            (d2_in.modrm),
      .sib              (d2_in.sib),
      .modrm_present    (d2_in.modrm_present),
      .sib_present      (d2_in.sib_present),
      .seg_id           (d2_in.seg_id),
      .segment_override (d2_in.segment_override),
      .seg              (seg_sel)
   );

   // register form vs memory form, only meaningful with a modrm byte
   assign mod_is_reg = d2_in.modrm_present && (d2_in.modrm.mod == 2'b11);
   assign mod_is_mem = d2_in.modrm_present && (d2_in.modrm.mod != 2'b11);

   assign op_0f7f = (d2_in.opcode == 16'h0F7F);

   // jmp/call far under 66 carry a 16:16 pointer
   assign offset_ovr = d2_in.operand_override
                       && ((d2_in.opcode == 16'h00EA) || (d2_in.opcode == 16'h009A));

   // 66 prefix drops to 16 bits unless the word pins the size
   assign ovr_size = d2_in.operand_override ? size_16 : size_32;
   assign op_size  = cw.mux_op_size ? cw.op_size : ovr_size;

   // sib base replaces rm when a sib byte follows
   assign base_reg = d2_in.sib_present ? d2_in.sib.base : d2_in.modrm.rm;

   always_comb begin
      d2_out.eip    = d2_in.eip + {28'h0, d2_in.instr_length};
      d2_out.cs     = d2_in.cs;
      d2_out.disp   = d2_in.disp_present ? disp : '0;
      d2_out.imm    = d2_in.imm_present ? imm : '0;
      d2_out.offset = d2_in.offset_present ? offset : '0;

      // memory operand addresses are always 32-bit
      d2_out.sr1_size = (mod_is_mem || cw.mux_sr1_size) ? size_32 : op_size;
      d2_out.sr2_size = cw.mux_sr2_size ? cw.sr2_size : op_size;
      d2_out.dr1_size = cw.mux_dr1_size ? size_32 : op_size;
      d2_out.dr2_size = cw.mux_dr2_size ? size_32 : op_size;
      // far call stores cs:eip, 32 bits under 66
      if (cw.is_far_call) begin
         d2_out.mem_size = d2_in.operand_override ? size_32 : size_64;
      end else begin
         d2_out.mem_size = op_size;
      end

      d2_out.sr1_needed  = cw.sr1_needed || mod_is_mem;
      d2_out.seg1_needed = cw.mux_seg1_needed ? cw.seg1_needed : mod_is_mem;
      // mm source operand only in the register form
      d2_out.mm1_needed  = cw.mm1_needed && mod_is_reg;

      d2_out.mem_rd = cw.mux_mem_rd ? cw.mem_rd : mod_is_mem;
      d2_out.mem_wr = cw.mux_mem_wr ? cw.dcache_write : mod_is_mem;
      d2_out.alu_op = cw.mux_alu_op ? cw.alu_op : d2_in.modrm.reg_op;

      // memory destination writes back through the dcache
      d2_out.ld_gpr1 = cw.ld_gpr1 && !mod_is_mem;
      d2_out.ld_mm   = cw.ld_mm || (mod_is_reg && op_0f7f);

      d2_out.sr1  = cw.mux_sr1 ? cw.sr1 : base_reg;
      d2_out.sr2  = cw.mux_sr2 ? cw.sr2 : d2_in.modrm.reg_op;
      d2_out.sr3  = d2_in.modrm.reg_op;
      d2_out.sr4  = d2_in.sib.index;
      d2_out.seg1 = cw.mux_seg1 ? seg_es : seg_sel;
      d2_out.seg2 = cw.mux_seg2 ? d2_in.modrm.reg_op : seg_ss;

      d2_out.sib_en    = d2_in.sib_present;
      d2_out.disp_en   = d2_in.disp_present;
      // mod 00 rm 101 is disp32 with no base
      d2_out.base_en   = !((d2_in.modrm.mod == 2'b00) && (d2_in.modrm.rm == reg_ebp));
      d2_out.mux_seg   = (d2_in.seg_id == seg_cs);
      // 0fb0 and 0fb1 differ only in bit 0
      d2_out.cmpxchg   = (d2_in.opcode[15:1] == 15'h07D8);
      d2_out.sib_scale = d2_in.sib.scale;
      d2_out.valid     = d2_in.valid;
   end

endmodule

//--- decode2/field_extract.sv
`timescale 1ns/1ps

module field_extract #(
   parameter int ir_bytes = 16
) (
   input  logic [ir_bytes*8-1:0]         ir,
   input  logic [$clog2(ir_bytes)-1:0]   disp_sel,
   input  x86_pkg::size_code_t           disp_size,
   input  logic [$clog2(ir_bytes)-1:0]   imm_sel,
   input  x86_pkg::size_code_t           imm_size,
   input  logic [$clog2(ir_bytes)-1:0]   off_sel,
   input  x86_pkg::size_code_t           offset_size,
   input  logic                          offset_ovr,
   output logic [31:0]                   disp,
   output logic [31:0]                   imm,
   output logic [47:0]                   offset
);
   import x86_pkg::*;

   // ir shifted so that the selected byte lands at bit 0
   logic [ir_bytes*8-1:0] disp_win;
   logic [ir_bytes*8-1:0] imm_win;
   logic [ir_bytes*8-1:0] off_win;

   // byte sign-extends, word zero-extends, dword as is
   function automatic logic [31:0] extend(input logic [31:0] raw, input size_code_t size);
      logic [31:0] res;
      case (size)
         size_8:  res = {{24{raw[7]}}, raw[7:0]};
         size_16: res = {16'h0000, raw[15:0]};
         default: res = raw;
      endcase
      return res;
   endfunction

   // byte positions scale by 8 bits
   assign disp_win = ir >> {disp_sel, 3'b000};
   assign imm_win  = ir >> {imm_sel, 3'b000};
   assign off_win  = ir >> {off_sel, 3'b000};

   // displacement and immediate share the same extension rules
   assign disp = extend(disp_win[31:0], disp_size);
   assign imm  = extend(imm_win[31:0], imm_size);

   // offset field
   // size_64 marks a far pointer, offset bytes first then the selector
   always_comb begin
      case (offset_size)
         size_8: begin
            offset = {40'h0, off_win[7:0]};
         end
         size_16: begin
            offset = {32'h0, off_win[15:0]};
         end
         size_32: begin
            offset = {16'h0, off_win[31:0]};
         end
         default: begin
            // 16:16 pointer under the operand override, selector in the top word
            if (offset_ovr) begin
               offset = {off_win[31:16], 16'h0000, off_win[15:0]};
            end else begin
               offset = off_win[47:0];
            end
         end
      endcase
   end

endmodule

//--- decode2/seg_select.sv
`timescale 1ns/1ps

module seg_select (
   input  logic [15:0]      opcode,
   input  x86_pkg::modrm_t  modrm,
   input  x86_pkg::sib_t    sib,
   input  logic             modrm_present,
   input  logic             sib_present,
   input  x86_pkg::seg_id_t seg_id,
   input  logic             segment_override,
   output x86_pkg::seg_id_t seg
);
   import x86_pkg::*;

   logic    sib_stack;
   logic    modrm_stack;
   logic    pp_legacy;
   logic    pp_ext;
   seg_id_t pp_seg;

   // esp as sib base
   assign sib_stack = sib_present && (sib.base == reg_esp);

   // ebp plus disp8 or disp32
   // mod 00 with rm 101 is a bare disp32 and stays on DS
   assign modrm_stack = modrm_present && (modrm.mod inside {2'b01, 2'b10})
                        && (modrm.rm == reg_ebp);

   // push/pop es cs ss ds: 06 07 0e 16 17 1e 1f
   // 0f is the two-byte escape, not pop cs
   assign pp_legacy = (opcode[15:8] == 8'h00) && (opcode[7:5] == 3'b000)
                      && (opcode[2:1] == 2'b11) && (opcode[7:0] != 8'h0F);

   // push/pop fs at 0f a0/a1, gs at 0f a8/a9
   assign pp_ext = (opcode[15:8] == 8'h0F) && (opcode[7:4] == 4'hA)
                   && (opcode[2:1] == 2'b00);

   // legacy forms carry the segment id directly in bits 4:3
   always_comb begin
      if (pp_ext) begin
         pp_seg = opcode[3] ? seg_gs : seg_fs;
      end else begin
         pp_seg = {1'b0, opcode[4:3]};
      end
   end

   // prefix first, then stack base, then push/pop, else DS
   always_comb begin
      if (segment_override) begin
         seg = seg_id;
      end else if (sib_stack || modrm_stack) begin
         seg = seg_ss;
      end else if (pp_legacy || pp_ext) begin
         seg = pp_seg;
      end else begin
         seg = seg_ds;
      end
   end

endmodule

//--- decode2/ucontrol_store.sv
`timescale 1ns/1ps

module ucontrol_store (
   input  ucode_pkg::ucode_addr_t addr,
   input  logic                   opcode_size,
   output ucode_pkg::ucode_word_t word
);
   import x86_pkg::*;

   // rom lookup, opcode_size picks the 0f half
   // anything not listed reads as zero, a no-op word
   always_comb begin
      word = '0;
      case ({opcode_size, addr})
         // add r/m32, r32; sizes follow 66, strobes follow mod
         {1'b0, 8'h01}: begin
            word.alu_op     = alu_add;
            word.mux_alu_op = 1'b1;
            word.sr1_needed = 1'b1;
            word.ld_gpr1    = 1'b1;
         end
         // mov r32, r/m32, never writes memory
         {1'b0, 8'h8B}: begin
            word.alu_op     = alu_add;
            word.mux_alu_op = 1'b1;
            word.mux_mem_wr = 1'b1;
            word.ld_gpr1    = 1'b1;
         end
         // push r32 and push sreg, esp drops by the operand size
         {1'b0, 8'h50}: begin
            word.alu_op       = alu_sub;
            word.mux_alu_op   = 1'b1;
            word.sr1          = reg_esp;
            word.mux_sr1      = 1'b1;
            word.mux_mem_rd   = 1'b1;
            word.dcache_write = 1'b1;
            word.mux_mem_wr   = 1'b1;
            word.ld_gpr1      = 1'b1;
            word.mux_dr1_size = 1'b1;
            word.sr1_needed   = 1'b1;
            word.mux_seg1_needed = 1'b1;
         end
         // pop r32 and pop sreg
         {1'b0, 8'h58}: begin
            word.alu_op       = alu_add;
            word.mux_alu_op   = 1'b1;
            word.sr1          = reg_esp;
            word.mux_sr1      = 1'b1;
            word.mem_rd       = 1'b1;
            word.mux_mem_rd   = 1'b1;
            word.mux_mem_wr   = 1'b1;
            word.ld_gpr1      = 1'b1;
            word.mux_dr1_size = 1'b1;
            word.sr1_needed   = 1'b1;
            word.mux_seg1_needed = 1'b1;
         end
         // call ptr16:32, cs and eip go onto the stack
         {1'b0, 8'h9A}: begin
            word.alu_op       = alu_sub;
            word.mux_alu_op   = 1'b1;
            word.sr1          = reg_esp;
            word.mux_sr1      = 1'b1;
            word.mux_mem_rd   = 1'b1;
            word.dcache_write = 1'b1;
            word.mux_mem_wr   = 1'b1;
            word.ld_gpr1      = 1'b1;
            word.mux_dr1_size = 1'b1;
            word.sr1_needed   = 1'b1;
            word.seg1_needed  = 1'b1;
            word.mux_seg1_needed = 1'b1;
            word.is_far_call  = 1'b1;
         end
         // cmpxchg r/m32, r32, compare against eax
         {1'b1, 8'hB1}: begin
            word.alu_op     = alu_cmp;
            word.mux_alu_op = 1'b1;
            word.sr1_needed = 1'b1;
            word.ld_gpr1    = 1'b1;
         end
         // movq mm/m64, mm
         {1'b1, 8'h7F}: begin
            word.op_size      = size_64;
            word.mux_op_size  = 1'b1;
            word.sr2_size     = size_64;
            word.mux_sr2_size = 1'b1;
            word.mux_mem_rd   = 1'b1;
            word.mm1_needed   = 1'b1;
         end
         default: begin
            word = '0;
         end
      endcase
   end

endmodule

//--- logic/d2_ag_latch.sv
`timescale 1ns/1ps

module d2_ag_latch (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             stall,
   input  logic             flush,
   input  x86_pkg::d2_out_t d,
   output x86_pkg::d2_out_t q
);

   // flush wins over stall, and only valid and the strobes clear
   // payload fields keep their last value until the next load
   always_ff @(posedge clk) begin
      if (!rst_n || flush) begin
         q.valid   <= 1'b0;
         q.mem_rd  <= 1'b0;
         q.mem_wr  <= 1'b0;
         q.ld_gpr1 <= 1'b0;
         q.ld_mm   <= 1'b0;
      end else if (!stall) begin
         q <= d;
      end
   end

endmodule

//--- logic/decode2_top.sv
`timescale 1ns/1ps

module decode2_top #(
   parameter int ir_bytes = x86_pkg::ir_len_bytes
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             stall,
   input  logic             flush,
   input  x86_pkg::d2_in_t  d2_in,
   output x86_pkg::d2_out_t d2_out
);
   import x86_pkg::*;

   // combinational AG bundle ahead of the pipeline register
   d2_out_t d2_comb;

   decode_stage2 #(
      .ir_bytes (ir_bytes)
   ) u_decode_stage2 (
      .d2_in  (d2_in),
      .d2_out (d2_comb)
   );

   d2_ag_latch u_d2_ag_latch (
      .clk   (clk),
      .rst_n (rst_n),
      .stall (stall),
      .flush (flush),
      .d     (d2_comb),
      .q     (d2_out)
   );

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the decode stage 2 testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_decode2 -f compile.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vtb_decode2 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Testbench passed" sim.log; then
   exit 0
fi
exit 1

//--- verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
   parameter int period_ns    = 40,
   parameter int reset_cycles = 2
) (
   output logic clk,
   output logic rst_n
);

   logic clk_r   = 1'b0;
   int   rst_cnt = 0;

   // free running clock
   always #(period_ns / 2) clk_r = ~clk_r;

   // reset stays low for the first reset_cycles rising edges
   always @(posedge clk_r) begin
      if (rst_cnt < reset_cycles) begin
         rst_cnt <= rst_cnt + 1;
      end
   end

   assign clk   = clk_r;
   assign rst_n = (rst_cnt >= reset_cycles);

endmodule

//--- verif/tb_decode2.sv
`timescale 1ns/1ps

module tb_decode2;
   import x86_pkg::*;

   // fields checked on the AG bundle, in table column order
   typedef struct packed {
      logic [31:0] eip;
      logic [31:0] disp;
      logic [31:0] imm;
      logic [47:0] offset;
      size_code_t  sr1_size;
      size_code_t  sr2_size;
      size_code_t  mem_size;
      logic        sr1_needed;
      logic        mem_rd;
      logic        mem_wr;
      logic        ld_gpr1;
      logic        ld_mm;
      seg_id_t     seg1;
      logic        base_en;
      logic        cmpxchg;
      logic        valid;
      alu_op_t     alu_op;
      reg_id_t     sr1;
      logic        seg1_needed;
      logic        mm1_needed;
   } exp_t;

   typedef struct packed {
      d2_in_t din;
      logic   stall;
      logic   flush;
      exp_t   want;
   } row_t;

   // byte k of the instruction register sits at bits 8k+7:8k
   localparam logic [ir_len_bytes*8-1:0] ir_image = 128'h0000_0000_0000_0856_78F7_C612_347F_8501;

   logic    clk;
   logic    rst_n;
   d2_in_t  d2_in = '0;
   logic    stall = 1'b0;
   logic    flush = 1'b0;
   d2_out_t dut_out;
   row_t    rows[$];
   int      row_idx = -1;
   int      errors  = 0;
   int      checks  = 0;

   tb_clock #(.period_ns(40), .reset_cycles(2)) clkgen (.clk(clk), .rst_n(rst_n));

   decode2_top #(.ir_bytes(ir_len_bytes)) dut0 (
      .clk    (clk),
      .rst_n  (rst_n),
      .stall  (stall),
      .flush  (flush),
      .d2_in  (d2_in),
      .d2_out (dut_out)
   );

   // the selected row is applied on the rising edge
   always @(posedge clk) begin
      if (row_idx >= 0) begin
         d2_in <= rows[row_idx].din;
         stall <= rows[row_idx].stall;
         flush <= rows[row_idx].flush;
      end
   end

   // common fields for one instruction, eip 1000 and a modrm byte
   function automatic d2_in_t make_in(input logic [15:0] opcode, input logic [7:0] uaddr,
                                      input logic [7:0] modrm, input logic [3:0] len);
      d2_in_t v;
      v = '0;
      v.ir            = ir_image;
      v.eip           = 32'h0000_1000;
      v.cs            = 16'h0008;
      v.instr_length  = len;
      v.opcode        = opcode;
      v.opcode_size   = (opcode[15:8] == 8'h0F);
      v.ucode_addr    = uaddr;
      v.modrm         = modrm;
      v.modrm_present = 1'b1;
      v.valid         = 1'b1;
      return v;
   endfunction

   task automatic add_row(input d2_in_t din, input logic st, input logic fl, input exp_t e);
      row_t r;
      r.din   = din;
      r.stall = st;
      r.flush = fl;
      r.want  = e;
      rows.push_back(r);
   endtask

   // columns: eip disp imm offset | sr1 sr2 mem size | sr1_needed mem_rd mem_wr
   // ld_gpr1 ld_mm | seg1 base_en cmpxchg valid | alu_op sr1 seg1_needed mm1_needed
   task automatic build_table();
      d2_in_t v;
      d2_in_t v_alu;
      exp_t   e;
      exp_t   e_alu;
      exp_t   e_movq;
      // add r/m32, r32 with a register mod
      v_alu = make_in(16'h0001, 8'h01, 8'hD1, 4'd2);
      e_alu = '{32'h0000_1002, 32'h0, 32'h0, 48'h0, 2'd2, 2'd2, 2'd2,
                1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 3'd3, 1'b1, 1'b0, 1'b1,
                3'd0, 3'd1, 1'b0, 1'b0};
      add_row(v_alu, 1'b0, 1'b0, e_alu);
      // same under 66, word immediate is zero-extended
      v = make_in(16'h0001, 8'h01, 8'hD1, 4'd4);
      v.operand_override = 1'b1;
      v.imm_present      = 1'b1;
      v.imm_sel          = 4'd5;
      v.imm_size         = size_16;
      e = '{32'h0000_1004, 32'h0, 32'h0000_F7C6, 48'h0, 2'd1, 2'd1, 2'd1,
            1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 3'd3, 1'b1, 1'b0, 1'b1,
            3'd0, 3'd1, 1'b0, 1'b0};
      add_row(v, 1'b0, 1'b0, e);
      // memory mod with ebp+disp8, stack base gives SS
      v = make_in(16'h0001, 8'h01, 8'h45, 4'd3);
      v.disp_present = 1'b1;
      v.disp_sel     = 4'd2;
      v.disp_size    = size_8;
      e = '{32'h0000_1003, 32'h0000_007F, 32'h0, 48'h0, 2'd2, 2'd2, 2'd2,
            1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 3'd2, 1'b1, 1'b0, 1'b1,
            3'd0, 3'd5, 1'b1, 1'b0};
      add_row(v, 1'b0, 1'b0, e);
      // memory mod under 66 with esp as sib base, negative disp8
      v = make_in(16'h0001, 8'h01, 8'h04, 4'd4);
      v.operand_override = 1'b1;
      v.sib_present      = 1'b1;
      v.sib              = 8'h4C;
      v.disp_present     = 1'b1;
      v.disp_sel         = 4'd1;
      v.disp_size        = size_8;
      e = '{32'h0000_1004, 32'hFFFF_FF85, 32'h0, 48'h0, 2'd2, 2'd1, 2'd1,
            1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 3'd2, 1'b1, 1'b0, 1'b1,
            3'd0, 3'd4, 1'b1, 1'b0};
      add_row(v, 1'b0, 1'b0, e);
      // fs prefix beats the ebp stack base
      v = make_in(16'h0001, 8'h01, 8'h5D, 4'd7);
      v.segment_override = 1'b1;
      v.seg_id           = seg_fs;
      v.disp_present     = 1'b1;
      v.disp_sel         = 4'd3;
      v.disp_size        = size_32;
      e = '{32'h0000_1007, 32'hF7C6_1234, 32'h0, 48'h0, 2'd2, 2'd2, 2'd2,
            1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 3'd4, 1'b1, 1'b0, 1'b1,
            3'd0, 3'd5, 1'b1, 1'b0};
      add_row(v, 1'b0, 1'b0, e);
      // mov r32, [disp32], no base register
      v = make_in(16'h008B, 8'h8B, 8'h15, 4'd6);
      v.disp_present = 1'b1;
      v.disp_sel     = 4'd3;
      v.disp_size    = size_32;
      e = '{32'h0000_1006, 32'hF7C6_1234, 32'h0, 48'h0, 2'd2, 2'd2, 2'd2,
            1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 3'd3, 1'b0, 1'b0, 1'b1,
            3'd0, 3'd5, 1'b1, 1'b0};
      add_row(v, 1'b0, 1'b0, e);
      // push es, segment from opcode bits
      v = make_in(16'h0006, 8'h50, 8'h00, 4'd1);
      v.modrm_present = 1'b0;
      e = '{32'h0000_1001, 32'h0, 32'h0, 48'h0, 2'd2, 2'd2, 2'd2,
            1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 3'd0, 1'b1, 1'b0, 1'b1,
            3'd5, 3'd4, 1'b0, 1'b0};
      add_row(v, 1'b0, 1'b0, e);
      // far call under 66 carries a 16:16 pointer
      v = make_in(16'h009A, 8'h9A, 8'h00, 4'd7);
      v.modrm_present    = 1'b0;
      v.operand_override = 1'b1;
      v.offset_present   = 1'b1;
      v.off_sel          = 4'd3;
      v.offset_size      = size_64;
      e = '{32'h0000_1007, 32'h0, 32'h0, 48'hF7C6_0000_1234, 2'd1, 2'd1, 2'd2,
            1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 3'd3, 1'b1, 1'b0, 1'b1,
            3'd5, 3'd4, 1'b1, 1'b0};
      add_row(v, 1'b0, 1'b0, e);
      // far call with a 16:32 pointer
      v.operand_override = 1'b0;
      e = '{32'h0000_1007, 32'h0, 32'h0, 48'h5678_F7C6_1234, 2'd2, 2'd2, 2'd3,
            1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 3'd3, 1'b1, 1'b0, 1'b1,
            3'd5, 3'd4, 1'b1, 1'b0};
      add_row(v, 1'b0, 1'b0, e);
      // cmpxchg r/m32, r32 register form
      v = make_in(16'h0FB1, 8'hB1, 8'hC8, 4'd3);
      e = '{32'h0000_1003, 32'h0, 32'h0, 48'h0, 2'd2, 2'd2, 2'd2,
            1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 3'd3, 1'b1, 1'b1, 1'b1,
            3'd7, 3'd0, 1'b0, 1'b0};
      add_row(v, 1'b0, 1'b0, e);
      // movq mm, mm register form loads the mm file
      v = make_in(16'h0F7F, 8'h7F, 8'hC1, 4'd3);
      e_movq = '{32'h0000_1003, 32'h0, 32'h0, 48'h0, 2'd3, 2'd3, 2'd3,
                 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 3'd3, 1'b1, 1'b0, 1'b1,
                 3'd0, 3'd1, 1'b0, 1'b1};
      add_row(v, 1'b0, 1'b0, e_movq);
      // stalled, new fields are ignored
      v = v_alu;
      v.eip = 32'h0000_2000;
      add_row(v, 1'b1, 1'b0, e_movq);
      // flush under stall clears valid and strobes only
      e = '{32'h0000_1003, 32'h0, 32'h0, 48'h0, 2'd3, 2'd3, 2'd3,
            1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 3'd3, 1'b1, 1'b0, 1'b0,
            3'd0, 3'd1, 1'b0, 1'b1};
      add_row(v, 1'b1, 1'b1, e);
      // pipeline resumes
      add_row(v_alu, 1'b0, 1'b0, e_alu);
   endtask

   task automatic compare_field(input string label, input string name,
                                input logic [47:0] got, input logic [47:0] want);
      checks++;
      if (got !== want) begin
         $display("ERR %s %s: got 0x%h expected 0x%h", label, name, got, want);
         errors++;
      end
   endtask

   task automatic check_out(input string label, input exp_t e);
      compare_field(label, "eip", 48'(dut_out.eip), 48'(e.eip));
      compare_field(label, "disp", 48'(dut_out.disp), 48'(e.disp));
      compare_field(label, "imm", 48'(dut_out.imm), 48'(e.imm));
      compare_field(label, "offset", dut_out.offset, e.offset);
      compare_field(label, "sr1_size", 48'(dut_out.sr1_size), 48'(e.sr1_size));
      compare_field(label, "sr2_size", 48'(dut_out.sr2_size), 48'(e.sr2_size));
      compare_field(label, "mem_size", 48'(dut_out.mem_size), 48'(e.mem_size));
      compare_field(label, "sr1_needed", 48'(dut_out.sr1_needed), 48'(e.sr1_needed));
      compare_field(label, "mem_rd", 48'(dut_out.mem_rd), 48'(e.mem_rd));
      compare_field(label, "mem_wr", 48'(dut_out.mem_wr), 48'(e.mem_wr));
      compare_field(label, "ld_gpr1", 48'(dut_out.ld_gpr1), 48'(e.ld_gpr1));
      compare_field(label, "ld_mm", 48'(dut_out.ld_mm), 48'(e.ld_mm));
      compare_field(label, "seg1", 48'(dut_out.seg1), 48'(e.seg1));
      compare_field(label, "base_en", 48'(dut_out.base_en), 48'(e.base_en));
      compare_field(label, "cmpxchg", 48'(dut_out.cmpxchg), 48'(e.cmpxchg));
      compare_field(label, "valid", 48'(dut_out.valid), 48'(e.valid));
      compare_field(label, "alu_op", 48'(dut_out.alu_op), 48'(e.alu_op));
      compare_field(label, "sr1", 48'(dut_out.sr1), 48'(e.sr1));
      compare_field(label, "seg1_needed", 48'(dut_out.seg1_needed), 48'(e.seg1_needed));
      compare_field(label, "mm1_needed", 48'(dut_out.mm1_needed), 48'(e.mm1_needed));
   endtask

   // drive on one edge, latch on the next, sample mid cycle
   task automatic run_table();
      for (int i = 0; i < rows.size(); i++) begin
         row_idx = i;
         @(posedge clk);
         @(posedge clk);
         @(negedge clk);
         check_out($sformatf("row %0d", i), rows[i].want);
      end
   endtask

   initial begin
      int wait_cnt;
      build_table();
      wait_cnt = 0;
      while (rst_n !== 1'b1 && wait_cnt < 10) begin
         @(negedge clk);
         wait_cnt++;
      end
      if (rst_n !== 1'b1) begin
         $display("reset was not released within 10 cycles");
         errors++;
      end else begin
         // nothing loaded yet
         compare_field("reset", "valid", 48'(dut_out.valid), 48'h0);
         compare_field("reset", "mem_rd", 48'(dut_out.mem_rd), 48'h0);
         compare_field("reset", "mem_wr", 48'(dut_out.mem_wr), 48'h0);
         compare_field("reset", "ld_gpr1", 48'(dut_out.ld_gpr1), 48'h0);
         compare_field("reset", "ld_mm", 48'(dut_out.ld_mm), 48'h0);
         run_table();
      end
      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule
